//--- bench/cpu_core_assert.sv
`timescale 1ns/1ns

module cpu_core_assert (
    input logic                 clk,
    input logic                 reset_n,
    input logic                 stall,
    input cpu_pkg::stage_ctrl_t ctrl,
    input logic                 retire_valid
);
    import cpu_pkg::*;

    logic [6:0] enables;
    logic [3:0] since_retire;

    assign enables = {ctrl.wb_if_wr_en, ctrl.if_id_wr_en, ctrl.id_ex_wr_en, ctrl.ex_mem_wr_en,
                      ctrl.mem_wb_wr_en, ctrl.ram_wr_en, ctrl.reg_wr_en};

    // saturating count of cycles since the last retire.
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            since_retire <= 4'd15;
        end else if (retire_valid) begin
            since_retire <= 4'd0;
        end else if (since_retire != 4'd15) begin
            since_retire <= since_retire + 4'd1;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n) $onehot0(enables))
        else $error("more than one stage enable is high");

    assert property (@(posedge clk) disable iff (!reset_n) stall |-> enables == 7'd0)
        else $error("stage enable high during stall");

    assert property (@(posedge clk) disable iff (!reset_n) retire_valid |-> since_retire >= 4'd8)
        else $error("retire pulses closer than nine cycles");

endmodule

bind cpu_core cpu_core_assert assert0 (
    .clk          (clk),
    .reset_n      (reset_n),
    .stall        (stall),
    .ctrl         (ctrl),
    .retire_valid (retire_valid)
);

//--- bench/tb_cpu_core.sv
`timescale 1ns/1ns

module tb_cpu_core;
    import cpu_pkg::*;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        run;
    logic        stall = 1'b0;
    logic        prog_we;
    prog_write_t prog;
    logic        retire_valid;
    retire_t     retire;
    logic        store_valid;
    store_t      store;

    logic        stall_en;
    logic        aborted;
    int          errors;
    int          tests_run;
    int          tests_failed;
    data_t       regs_m [num_regs];
    data_t       ram_m [dmem_depth];
    instr_t      prog_q [imem_depth];

    cpu_core dut0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .run          (run),
        .stall        (stall),
        .prog_we      (prog_we),
        .prog         (prog),
        .retire_valid (retire_valid),
        .retire       (retire),
        .store_valid  (store_valid),
        .store        (store)
    );

    always #2 clk = ~clk;

    // roughly one stalled cycle in four while stalls are enabled.
    always @(posedge clk) begin
        stall <= stall_en && ($urandom % 4 == 0);
    end

    function automatic instr_t gen_instr(input int kind);
        int sel;
        sel = $urandom_range(0, 3);
        if (kind == 0) begin
            return {4'($urandom_range(0, 5)), 3'($urandom), 3'($urandom), 6'($urandom)};
        end
        // loads and stores use a small window around r0 so that loads hit stored bytes.
        case (sel)
            0: return {4'd5, 3'($urandom), 3'($urandom), 6'($urandom)};
            2: return {4'd6, 3'($urandom), 3'd0, 6'($urandom_range(0, 7) - 4)};
            default: return {4'd7, 3'($urandom), 3'd0, 6'($urandom_range(0, 7) - 4)};
        endcase
    endfunction

    task automatic clear_model();
        for (int i = 0; i < num_regs; i++) begin
            regs_m[i] = '0;
        end
        for (int i = 0; i < dmem_depth; i++) begin
            ram_m[i] = '0;
        end
    endtask

    // reference model of one instruction, straight from the encoding rules.
    task automatic model_step(input instr_t w, output logic is_st, output retire_t r,
                              output store_t s);
        logic [3:0] op;
        data_t      a;
        data_t      b;
        data_t      imm;
        data_t      sum;
        data_t      val;
        op = w[15:12];
        a = regs_m[w[8:6]];
        b = regs_m[w[2:0]];
        imm = {{2{w[5]}}, w[5:0]};
        sum = a + imm;
        is_st = 1'b0;
        val = '0;
        s = '0;
        case (op)
            4'd0: val = a + b;
            4'd1: val = a - b;
            4'd2: val = a & b;
            4'd3: val = a | b;
            4'd4: val = a ^ b;
            4'd5: val = sum;
            4'd6: val = ram_m[sum[5:0]];
            default: begin
                is_st = 1'b1;
                s.addr = sum[5:0];
                s.value = regs_m[w[11:9]];
                ram_m[sum[5:0]] = regs_m[w[11:9]];
            end
        endcase
        r.rd = w[11:9];
        r.value = val;
        if (!is_st) begin
            regs_m[w[11:9]] = val;
        end
    endtask

    task automatic check_retire(input retire_t exp, input retire_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t retire exp=%h act=%h", $time, exp, act);
            errors++;
        end
    endtask

    task automatic check_store(input store_t exp, input store_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t store exp=%h act=%h", $time, exp, act);
            errors++;
        end
    endtask

    task automatic check_spacing(input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %0t retire_spacing exp=%0d act=%0d", $time, exp, act);
            errors++;
        end
    endtask

    task automatic load_program(input int n, input int kind);
        prog_write_t p;
        for (int i = 0; i < n; i++) begin
            prog_q[i] = gen_instr(kind);
            p.addr = pc_t'(i);
            p.data = prog_q[i];
            @(posedge clk);
            prog_we <= 1'b1;
            prog <= p;
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // counts cycles up to the next pulse and the stalled cycles on the way.
    task automatic wait_event(output int gap, output int stalls);
        logic found;
        gap = 0;
        stalls = 0;
        found = 1'b0;
        while (!found && gap < 40) begin
            @(posedge clk);
            gap++;
            if (retire_valid || store_valid) begin
                found = 1'b1;
            end else if (stall) begin
                stalls++;
            end
        end
        if (!found) begin
            $display("timeout at %0t: no retire or store pulse within 40 cycles", $time);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_program(input int n, input bit timing, input bit drop_run);
        logic    is_st;
        retire_t er;
        store_t  es;
        int      gap;
        int      stalls;
        @(posedge clk);
        run <= 1'b1;
        for (int i = 0; i < n && !aborted; i++) begin
            model_step(prog_q[i], is_st, er, es);
            wait_event(gap, stalls);
            if (!aborted) begin
                if (is_st && !store_valid) begin
                    $display("instruction %0d at %0t retired where a store was due", i, $time);
                    errors++;
                end else if (!is_st && !retire_valid) begin
                    $display("instruction %0d at %0t stored where a retire was due", i, $time);
                    errors++;
                end else if (is_st) begin
                    check_store(es, store);
                end else begin
                    check_retire(er, retire);
                end
                if (timing) begin
                    check_spacing(phases_per_instr + stalls, gap);
                end
            end
        end
        if (drop_run) begin
            @(posedge clk);
            run <= 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int err0;
        void'($urandom(32'h3845));
        reset_n = 1'b0;
        run = 1'b0;
        prog_we = 1'b0;
        prog = '0;
        stall_en = 1'b0;
        aborted = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        clear_model();
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;

        err0 = errors;
        load_program(40, 0);
        run_program(40, 1'b0, 1'b1);
        report_test("alu_program", err0);

        err0 = errors;
        load_program(48, 1);
        run_program(48, 1'b0, 1'b1);
        report_test("memory_program", err0);

        err0 = errors;
        load_program(20, 0);
        run_program(20, 1'b1, 1'b1);
        report_test("phase_timing", err0);

        err0 = errors;
        stall_en = 1'b1;
        load_program(30, 0);
        run_program(30, 1'b1, 1'b1);
        stall_en = 1'b0;
        report_test("stall", err0);

        err0 = errors;
        load_program(20, 1);
        run_program(4, 1'b0, 1'b0); // leaves the core running.
        @(posedge clk);
        reset_n <= 1'b0;
        run <= 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            if (i == 8) begin
                reset_n <= 1'b1;
            end
            if (retire_valid || store_valid) begin
                $display("pulse at %0t while reset or idle after reset", $time);
                errors++;
            end
        end
        clear_model();
        run_program(20, 1'b0, 1'b1);
        report_test("reset_mid_run", err0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/1ns

module cpu_core (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 run,
    input  logic                 stall,
    input  logic                 prog_we,
    input  cpu_pkg::prog_write_t prog,
    output logic                 retire_valid,
    output cpu_pkg::retire_t     retire,
    output logic                 store_valid,
    output cpu_pkg::store_t      store
);
    import cpu_pkg::*;

    stage_ctrl_t ctrl;
    instr_t      instr;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    data_t       rdata1;
    data_t       rdata2;
    decoded_t    dec_q;
    data_t       result;
    data_t       store_value;
    logic        wb_we;
    retire_t     wb;

    assign retire_valid = ctrl.reg_wr_en && wb_we; // doubles as the register file write enable.
    assign retire = wb;

    cpu_sequencer seq0 (
        .clk     (clk),
        .reset_n (reset_n),
        .run     (run),
        .stall   (stall),
        .ctrl    (ctrl)
    );

    fetch_unit fetch0 (
        .clk     (clk),
        .reset_n (reset_n),
        .ctrl    (ctrl),
        .prog_we (prog_we),
        .prog    (prog),
        .run     (run),
        .instr   (instr)
    );

    register_file rf0 (
        .clk     (clk),
        .reset_n (reset_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .we      (retire_valid),
        .wr      (wb)
    );

    execute_unit ex0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .ctrl        (ctrl),
        .instr       (instr),
        .rs1         (rs1),
        .rs2         (rs2),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .dec_q       (dec_q),
        .result      (result),
        .store_value (store_value)
    );

    data_memory dmem0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .ctrl        (ctrl),
        .dec_q       (dec_q),
        .result      (result),
        .store_value (store_value),
        .wb_we       (wb_we),
        .wb          (wb),
        .store_valid (store_valid),
        .store       (store)
    );

endmodule

//--- hdl/cpu_pkg.sv
package cpu_pkg;

    localparam int num_regs = 8;
    localparam int imem_depth = 64;
    localparam int dmem_depth = 64;
    localparam int phases_per_instr = 9; // cycles from st_if through st_wb_if.

    typedef logic [7:0] data_t;
    typedef logic [2:0] reg_idx_t;
    typedef logic [5:0] pc_t;
    typedef logic [5:0] dmem_addr_t;
    typedef logic [15:0] instr_t;

    // codes 8 to 15 decode as no-ops and retire nothing.
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_addi = 4'd5,
        op_ld   = 4'd6,
        op_st   = 4'd7
    } opcode_t;

    typedef enum logic [3:0] {
        st_init,
        st_if,
        st_if_id,
        st_id,
        st_id_ex,
        st_ex_mem,
        st_mem,
        st_mem_wb,
        st_wb,
        st_wb_if
    } seq_state_t;

    typedef struct packed {
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        data_t    imm; // sign-extended from the 6-bit field.
    } decoded_t;

    typedef struct packed {
        logic wb_if_wr_en;
        logic if_id_wr_en;
        logic id_ex_wr_en;
        logic ex_mem_wr_en;
        logic mem_wb_wr_en;
        logic ram_wr_en;
        logic reg_wr_en;
        logic pipeline_register_reset_n;
    } stage_ctrl_t;

    typedef struct packed {
        pc_t    addr;
        instr_t data;
    } prog_write_t;

    typedef struct packed {
        reg_idx_t rd;
        data_t    value;
    } retire_t;

    typedef struct packed {
        dmem_addr_t addr;
        data_t      value;
    } store_t;

endpackage

//--- hdl/cpu_sequencer.sv
`timescale 1ns/1ns

module cpu_sequencer (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 run,
    input  logic                 stall,
    output cpu_pkg::stage_ctrl_t ctrl
);
    import cpu_pkg::*;

    seq_state_t state;
    seq_state_t state_next;

    always_comb begin
        case (state)
            st_init: state_next = st_if;
            st_if: state_next = st_if_id;
            st_if_id: state_next = st_id;
            st_id: state_next = st_id_ex;
            st_id_ex: state_next = st_ex_mem;
            st_ex_mem: state_next = st_mem;
            st_mem: state_next = st_mem_wb;
            st_mem_wb: state_next = st_wb;
            st_wb: state_next = st_wb_if;
            st_wb_if: state_next = st_if;
            default: state_next = st_init;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n || !run) begin
            state <= st_init; // dropping run abandons the instruction in flight.
        end else if (!stall) begin
            state <= state_next;
        end
    end

    // one enable per phase, none while stalled.
    always_comb begin
        ctrl = '0;
        ctrl.pipeline_register_reset_n = (state != st_init);
        if (!stall) begin
            case (state)
                st_if_id: begin
                    ctrl.if_id_wr_en = 1'b1;
                end
                st_id_ex: begin
                    ctrl.id_ex_wr_en = 1'b1;
                end
                st_ex_mem: begin
                    ctrl.ex_mem_wr_en = 1'b1;
                end
                st_mem: begin
                    ctrl.ram_wr_en = 1'b1;
                end
                st_mem_wb: begin
                    ctrl.mem_wb_wr_en = 1'b1;
                end
                st_wb: begin
                    ctrl.reg_wr_en = 1'b1;
                end
                st_wb_if: begin
                    ctrl.wb_if_wr_en = 1'b1;
                end
                default: begin
                    ctrl.wb_if_wr_en = 1'b0; // init, fetch and decode only settle.
                end
            endcase
        end
    end

endmodule

//--- hdl/data_memory.sv
`timescale 1ns/1ns

module data_memory (
    input  logic                 clk,
    input  logic                 reset_n,
    input  cpu_pkg::stage_ctrl_t ctrl,
    input  cpu_pkg::decoded_t    dec_q,
    input  cpu_pkg::data_t       result,
    input  cpu_pkg::data_t       store_value,
    output logic                 wb_we,
    output cpu_pkg::retire_t     wb,
    output logic                 store_valid,
    output cpu_pkg::store_t      store
);
    import cpu_pkg::*;

    data_t      ram [dmem_depth];
    dmem_addr_t addr;
    logic       is_store;
    logic       writes_reg;

    assign addr = result[5:0]; // the upper address bits are ignored.
    assign is_store = (dec_q.op == op_st);
    assign writes_reg = dec_q.op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi, op_ld};

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < dmem_depth; i++) begin
                ram[i] <= '0;
            end
        end else if (ctrl.ram_wr_en && is_store) begin
            ram[addr] <= store_value;
        end
    end

    always_comb begin
        store_valid = ctrl.ram_wr_en && is_store;
        store.addr = addr;
        store.value = store_value;
    end

    always_ff @(posedge clk) begin
        if (!reset_n || !ctrl.pipeline_register_reset_n) begin
            wb_we <= 1'b0;
        end else if (ctrl.mem_wb_wr_en) begin
            wb_we <= writes_reg; // stores and no-ops leave the register file alone.
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.mem_wb_wr_en) begin
            wb.rd <= dec_q.rd;
            wb.value <= (dec_q.op == op_ld) ? ram[addr] : result;
        end
    end

endmodule

//--- hdl/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
    input  logic                 clk,
    input  logic                 reset_n,
    input  cpu_pkg::stage_ctrl_t ctrl,
    input  cpu_pkg::instr_t      instr,
    output cpu_pkg::reg_idx_t    rs1,
    output cpu_pkg::reg_idx_t    rs2,
    input  cpu_pkg::data_t       rdata1,
    input  cpu_pkg::data_t       rdata2,
    output cpu_pkg::decoded_t    dec_q,
    output cpu_pkg::data_t       result,
    output cpu_pkg::data_t       store_value
);
    import cpu_pkg::*;

    decoded_t dec;
    data_t    op_a;
    data_t    op_b;
    data_t    alu_b;
    data_t    alu_out;

    always_comb begin
        dec.op = opcode_t'(instr[15:12]);
        dec.rd = instr[11:9];
        dec.rs1 = instr[8:6];
        dec.rs2 = instr[2:0];
        dec.imm = {{2{instr[5]}}, instr[5:0]};
    end

    assign rs1 = dec.rs1;
    // a store reads its data register through the second port.
    assign rs2 = (dec.op == op_st) ? dec.rd : dec.rs2;

    always_ff @(posedge clk) begin
        if (!reset_n || !ctrl.pipeline_register_reset_n) begin
            dec_q <= '0;
        end else if (ctrl.id_ex_wr_en) begin
            dec_q <= dec;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.id_ex_wr_en) begin
            op_a <= rdata1;
            op_b <= rdata2;
        end
    end

    always_comb begin
        alu_b = (dec_q.op inside {op_addi, op_ld, op_st}) ? dec_q.imm : op_b;
        case (dec_q.op)
            op_add, op_addi, op_ld, op_st: alu_out = op_a + alu_b; // loads and stores form their address here.
            op_sub: alu_out = op_a - alu_b;
            op_and: alu_out = op_a & alu_b;
            op_or: alu_out = op_a | alu_b;
            op_xor: alu_out = op_a ^ alu_b;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.ex_mem_wr_en) begin
            result <= alu_out;
            store_value <= op_b;
        end
    end

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                 clk,
    input  logic                 reset_n,
    input  cpu_pkg::stage_ctrl_t ctrl,
    input  logic                 prog_we,
    input  cpu_pkg::prog_write_t prog,
    input  logic                 run,
    output cpu_pkg::instr_t      instr
);
    import cpu_pkg::*;

    instr_t imem [imem_depth];
    pc_t    pc;

    always_ff @(posedge clk) begin
        if (prog_we && !run) begin
            imem[prog.addr] <= prog.data; // loading only happens while the core is idle.
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || !ctrl.pipeline_register_reset_n) begin
            pc <= '0; // every run starts at address 0.
        end else if (ctrl.wb_if_wr_en) begin
            pc <= pc + pc_t'(1); // wraps at 64 with no branch logic.
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || !ctrl.pipeline_register_reset_n) begin
            instr <= '0;
        end else if (ctrl.if_id_wr_en) begin
            instr <= imem[pc];
        end
    end

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic              clk,
    input  logic              reset_n,
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    output cpu_pkg::data_t    rdata1,
    output cpu_pkg::data_t    rdata2,
    input  logic              we,
    input  cpu_pkg::retire_t  wr
);
    import cpu_pkg::*;

    data_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr.rd] <= wr.value;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

//--- mcycle_cpu.f
hdl/cpu_pkg.sv
hdl/cpu_sequencer.sv
hdl/fetch_unit.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/data_memory.sv
hdl/cpu_core.sv
bench/cpu_core_assert.sv
bench/tb_cpu_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cpu_core -f mcycle_cpu.f -o sim_cpu \
    && ./obj_dir/sim_cpu > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0
